/* include/dma_defs.svh */
// Width and depth macros for the DMA backend; include wherever a width or depth is needed
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// --------------------
// Datapath widths
// --------------------

// Byte address width
`define DMA_ADDR_WIDTH 24
// Word width in bits
`define DMA_DATA_WIDTH 32
// Transfer length in bytes
`define DMA_LEN_WIDTH 16
// Byte offset bits inside one word, log2 of DMA_DATA_WIDTH/8
`define DMA_OFFSET_WIDTH 2

// --------------------
// Queue depths
// --------------------

// Words in the read to write buffer
`define DMA_FIFO_DEPTH 4
// Jobs in flight per engine and in the response order queue
`define DMA_JOB_DEPTH 2

`endif

/* src/dma_pkg.sv */
// Shared types of the DMA backend; modules import them with a wildcard in their header
`include "dma_defs.svh"

package dma_pkg;

    // Meaningful widths
    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DMA_DATA_WIDTH-1:0] data_t;
    typedef logic [`DMA_LEN_WIDTH-1:0] len_t;
    // Word count, the length without its byte offset bits
    typedef logic [`DMA_LEN_WIDTH-`DMA_OFFSET_WIDTH-1:0] beat_cnt_t;

    // 1D transfer request
    typedef struct packed {
        addr_t src_addr;
        addr_t dst_addr;
        len_t  length;
        logic  last;
    } dma_req_t;

    // One response per request
    typedef struct packed {
        logic last;
        logic error;
    } dma_rsp_t;

    // Job handed to each engine
    typedef struct packed {
        addr_t     addr;
        beat_cnt_t beats;
    } job_t;

    typedef struct packed {
        logic front_busy;
        logic rd_busy;
        logic buf_busy;
        logic wr_busy;
        logic rsp_busy;
    } dma_busy_t;

    // Read port, req/gnt with data one cycle after gnt
    typedef struct packed {
        logic  req;
        addr_t addr;
    } rd_port_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        data_t rdata;
        logic  rerr;
    } rd_port_rsp_t;

    // OBI-style write port, done at gnt
    typedef struct packed {
        logic  req;
        addr_t addr;
        data_t wdata;
    } wr_port_req_t;

    typedef struct packed {
        logic gnt;
    } wr_port_rsp_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_WAIT
    } rd_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_WRITE
    } wr_state_e;

endpackage

/* src/dma_req_front.sv */
// Request front end; forks each accepted transfer to the read engine, write engine and order queue
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_req_front import dma_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // Incoming transfer
    input  dma_req_t dma_req_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    // Read job
    output job_t     rd_job_o,
    output logic     rd_job_valid_o,
    input  logic     rd_job_ready_i,
    // Write job
    output job_t     wr_job_o,
    output logic     wr_job_valid_o,
    input  logic     wr_job_ready_i,
    // Order entry for the response unit
    output logic     ord_last_o,
    output logic     ord_zero_o,
    output logic     ord_valid_o,
    input  logic     ord_ready_i,
    output logic     busy_o
);

    logic      is_zero;
    beat_cnt_t beats;
    // Outputs already taken for the current request
    logic      rd_done_q;
    logic      wr_done_q;
    logic      ord_done_q;
    // Output taken before or taken now
    logic      rd_ok;
    logic      wr_ok;
    logic      ord_ok;

    // --------------------
    // Job build
    // --------------------
    assign is_zero = dma_req_i.length == '0;
    // Lengths are word multiples, so dropping the offset bits gives the word count
    assign beats   = dma_req_i.length[`DMA_LEN_WIDTH-1:`DMA_OFFSET_WIDTH];

    assign rd_job_o   = '{addr: dma_req_i.src_addr, beats: beats};
    assign wr_job_o   = '{addr: dma_req_i.dst_addr, beats: beats};
    assign ord_last_o = dma_req_i.last;
    assign ord_zero_o = is_zero;

    // --------------------
    // Stream fork
    // --------------------
    // Zero lengths only send the order entry
    assign rd_job_valid_o = req_valid_i & ~is_zero & ~rd_done_q;
    assign wr_job_valid_o = req_valid_i & ~is_zero & ~wr_done_q;
    assign ord_valid_o    = req_valid_i & ~ord_done_q;

    assign rd_ok  = is_zero | rd_done_q | rd_job_ready_i;
    assign wr_ok  = is_zero | wr_done_q | wr_job_ready_i;
    assign ord_ok = ord_done_q | ord_ready_i;

    // Request leaves once all three parts are out
    assign req_ready_o = req_valid_i & rd_ok & wr_ok & ord_ok;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_done_q  <= 1'b0;
            wr_done_q  <= 1'b0;
            ord_done_q <= 1'b0;
        end else if (req_ready_o) begin
            rd_done_q  <= 1'b0;
            wr_done_q  <= 1'b0;
            ord_done_q <= 1'b0;
        end else begin
            if (rd_job_valid_o && rd_job_ready_i) rd_done_q <= 1'b1;
            if (wr_job_valid_o && wr_job_ready_i) wr_done_q <= 1'b1;
            if (ord_valid_o && ord_ready_i) ord_done_q <= 1'b1;
        end
    end

    // Busy while a request is half forked
    assign busy_o = rd_done_q | wr_done_q | ord_done_q;

endmodule

/* src/dma_read_engine.sv */
// Read engine; walks a read job word by word and pushes returned data into the word buffer
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_read_engine import dma_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    // Job from the front
    input  job_t         job_i,
    input  logic         job_valid_i,
    output logic         job_ready_o,
    // Read port
    output rd_port_req_t rd_port_o,
    input  rd_port_rsp_t rd_port_i,
    // Buffer push side
    output data_t        data_o,
    output logic         data_valid_o,
    input  logic         data_ready_i,
    input  logic [$clog2(`DMA_FIFO_DEPTH+1)-1:0] free_slots_i,
    // Job done with its read error
    output logic         done_o,
    output logic         done_err_o,
    output logic         busy_o
);

    rd_state_e state_q;
    addr_t     addr_q;
    beat_cnt_t left_q;
    logic      err_q;
    logic      issue;
    logic      beat_in;

    // One read at most in flight; the slot for it is reserved before the request goes out
    assign issue   = (state_q == RD_REQ) & (free_slots_i != '0) & data_ready_i;
    // Data shows up exactly one cycle after gnt
    assign beat_in = (state_q == RD_WAIT) & rd_port_i.rvalid;

    assign job_ready_o    = state_q == RD_IDLE;
    assign rd_port_o.req  = issue;
    assign rd_port_o.addr = addr_q;

    // Straight forward to the buffer
    assign data_o       = rd_port_i.rdata;
    assign data_valid_o = beat_in;

    // Done on the final beat, error includes this beat
    assign done_o     = beat_in & (left_q == beat_cnt_t'(1));
    assign done_err_o = err_q | rd_port_i.rerr;
    assign busy_o     = state_q != RD_IDLE;

    // --------------------
    // Read FSM
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RD_IDLE;
            addr_q  <= '0;
            left_q  <= '0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (job_valid_i) begin
                        addr_q  <= job_i.addr;
                        left_q  <= job_i.beats;
                        err_q   <= 1'b0;
                        state_q <= RD_REQ;
                    end
                end
                RD_REQ: begin
                    // Request held until gnt
                    if (issue && rd_port_i.gnt) state_q <= RD_WAIT;
                end
                RD_WAIT: begin
                    if (beat_in) begin
                        err_q  <= err_q | rd_port_i.rerr;
                        addr_q <= addr_q + addr_t'(`DMA_DATA_WIDTH / 8);
                        left_q <= left_q - beat_cnt_t'(1);
                        state_q <= done_o ? RD_IDLE : RD_REQ;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

endmodule

/* src/dma_data_fifo.sv */
// Word buffer between the read and write engines; reports free slots for read slot reservation
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_data_fifo import dma_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    // Push side
    input  data_t data_i,
    input  logic  valid_i,
    output logic  ready_o,
    // Pop side
    output data_t data_o,
    output logic  valid_o,
    input  logic  ready_i,
    output logic [$clog2(`DMA_FIFO_DEPTH+1)-1:0] free_slots_o,
    output logic  busy_o
);

    localparam int unsigned Depth    = `DMA_FIFO_DEPTH;
    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    data_t               mem_q [Depth];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] cnt_q;
    logic                push;
    logic                pop;

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    assign ready_o      = cnt_q != CntWidth'(Depth);
    assign valid_o      = cnt_q != '0;
    assign data_o       = mem_q[rd_ptr_q];
    assign free_slots_o = CntWidth'(Depth) - cnt_q;
    assign busy_o       = valid_o;

    // Storage, readable the cycle after the write
    always_ff @(posedge clk_i) begin
        if (push) mem_q[wr_ptr_q] <= data_i;
    end

    // --------------------
    // Pointers and fill count
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CntWidth'(push) - CntWidth'(pop);
        end
    end

endmodule

/* src/dma_write_engine.sv */
// Write engine; pops buffered words and writes them out over the OBI-style port
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_write_engine import dma_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    // Job from the front
    input  job_t         job_i,
    input  logic         job_valid_i,
    output logic         job_ready_o,
    // Buffer pop side
    input  data_t        data_i,
    input  logic         data_valid_i,
    output logic         data_ready_o,
    // Write port
    output wr_port_req_t wr_port_o,
    input  wr_port_rsp_t wr_port_i,
    output logic         done_o,
    output logic         busy_o
);

    wr_state_e state_q;
    addr_t     addr_q;
    beat_cnt_t left_q;
    logic      beat_out;

    // Head word stays put until popped, so req, addr and wdata hold until gnt
    assign wr_port_o.req   = (state_q == WR_WRITE) & data_valid_i;
    assign wr_port_o.addr  = addr_q;
    assign wr_port_o.wdata = data_i;

    // Write complete at gnt
    assign beat_out     = wr_port_o.req & wr_port_i.gnt;
    assign data_ready_o = beat_out;

    assign job_ready_o = state_q == WR_IDLE;
    assign done_o      = beat_out & (left_q == beat_cnt_t'(1));
    assign busy_o      = state_q != WR_IDLE;

    // --------------------
    // Write FSM
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= WR_IDLE;
            addr_q  <= '0;
            left_q  <= '0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (job_valid_i) begin
                        addr_q  <= job_i.addr;
                        left_q  <= job_i.beats;
                        state_q <= WR_WRITE;
                    end
                end
                WR_WRITE: begin
                    if (beat_out) begin
                        addr_q <= addr_q + addr_t'(`DMA_DATA_WIDTH / 8);
                        left_q <= left_q - beat_cnt_t'(1);
                        // back to idle after the last word
                        if (done_o) state_q <= WR_IDLE;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

endmodule

/* src/dma_rsp_unit.sv */
// Response unit; answers requests in order, merging read errors with write completions
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_rsp_unit import dma_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // Order entries from the front
    input  logic     ord_last_i,
    input  logic     ord_zero_i,
    input  logic     ord_valid_i,
    output logic     ord_ready_o,
    // Engine results
    input  logic     rd_done_i,
    input  logic     rd_err_i,
    input  logic     wr_done_i,
    // Response
    output dma_rsp_t dma_rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    output logic     busy_o
);

    localparam int unsigned Depth       = `DMA_JOB_DEPTH;
    localparam int unsigned PtrWidth    = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth    = $clog2(Depth + 1);
    // Engines may finish one forked job before its order entry gets a slot
    localparam int unsigned ResDepth    = Depth + 1;
    localparam int unsigned ResCntWidth = $clog2(ResDepth + 1);

    // Order queue, circular
    logic                   ord_last_q [Depth];
    logic                   ord_zero_q [Depth];
    logic [PtrWidth-1:0]    ord_wr_ptr_q;
    logic [PtrWidth-1:0]    ord_rd_ptr_q;
    logic [CntWidth-1:0]    ord_cnt_q;
    // Read error flags, oldest at index 0
    logic                   err_q [ResDepth];
    logic [ResCntWidth-1:0] err_cnt_q;
    // Write jobs finished but not yet answered
    logic [ResCntWidth-1:0] wr_pend_q;

    logic ord_push;
    logic rsp_fire;
    logic head_zero;
    logic data_pop;

    assign ord_push  = ord_valid_i & ord_ready_o;
    assign rsp_fire  = rsp_valid_o & rsp_ready_i;
    assign head_zero = ord_zero_q[ord_rd_ptr_q];
    // Normal entries also retire one read error and one write completion
    assign data_pop  = rsp_fire & ~head_zero;

    assign ord_ready_o = ord_cnt_q != CntWidth'(Depth);

    // --------------------
    // Response
    // --------------------
    // Zero head answers at once, else wait for its write completion
    assign rsp_valid_o = (ord_cnt_q != '0) &
                         (head_zero | ((wr_pend_q != '0) & (err_cnt_q != '0)));
    assign dma_rsp_o   = '{last: ord_last_q[ord_rd_ptr_q], error: head_zero | err_q[0]};
    assign busy_o      = ord_cnt_q != '0;

    always_ff @(posedge clk_i) begin
        if (ord_push) begin
            ord_last_q[ord_wr_ptr_q] <= ord_last_i;
            ord_zero_q[ord_wr_ptr_q] <= ord_zero_i;
        end
        if (data_pop) begin
            for (int i = 0; i < ResDepth - 1; i++) err_q[i] <= err_q[i+1];
        end
        // Tail slot moves down by one when popping in the same cycle
        if (rd_done_i) err_q[err_cnt_q - ResCntWidth'(data_pop)] <= rd_err_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ord_wr_ptr_q <= '0;
            ord_rd_ptr_q <= '0;
            ord_cnt_q    <= '0;
            err_cnt_q    <= '0;
            wr_pend_q    <= '0;
        end else begin
            if (ord_push) begin
                ord_wr_ptr_q <= (ord_wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : ord_wr_ptr_q + 1'b1;
            end
            if (rsp_fire) begin
                ord_rd_ptr_q <= (ord_rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : ord_rd_ptr_q + 1'b1;
            end
            ord_cnt_q <= ord_cnt_q + CntWidth'(ord_push) - CntWidth'(rsp_fire);
            err_cnt_q <= err_cnt_q + ResCntWidth'(rd_done_i) - ResCntWidth'(data_pop);
            wr_pend_q <= wr_pend_q + ResCntWidth'(wr_done_i) - ResCntWidth'(data_pop);
        end
    end

endmodule

/* src/dma_backend.sv */
// Top level of the 1D DMA backend; connects front, engines, word buffer and response unit
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_backend import dma_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    // Transfer request
    input  dma_req_t     dma_req_i,
    input  logic         req_valid_i,
    output logic         req_ready_o,
    // Transfer response
    output dma_rsp_t     dma_rsp_o,
    output logic         rsp_valid_o,
    input  logic         rsp_ready_i,
    // Memory ports
    output rd_port_req_t rd_port_o,
    input  rd_port_rsp_t rd_port_i,
    output wr_port_req_t wr_port_o,
    input  wr_port_rsp_t wr_port_i,
    output dma_busy_t    busy_o
);

    // Front to engines and response unit
    job_t  rd_job;
    job_t  wr_job;
    logic  rd_job_valid, rd_job_ready;
    logic  wr_job_valid, wr_job_ready;
    logic  ord_last, ord_zero, ord_valid, ord_ready;
    // Read engine to buffer
    data_t rd_data;
    logic  rd_data_valid, rd_data_ready;
    logic [$clog2(`DMA_FIFO_DEPTH+1)-1:0] free_slots;
    // Buffer to write engine
    data_t wr_data;
    logic  wr_data_valid, wr_data_ready;
    // Engine results
    logic  rd_done, rd_err, wr_done;

    dma_req_front i_dma_req_front (
        .clk_i, .arst_n_i, .dma_req_i, .req_valid_i, .req_ready_o,
        .rd_job_o       ( rd_job            ),
        .rd_job_valid_o ( rd_job_valid      ),
        .rd_job_ready_i ( rd_job_ready      ),
        .wr_job_o       ( wr_job            ),
        .wr_job_valid_o ( wr_job_valid      ),
        .wr_job_ready_i ( wr_job_ready      ),
        .ord_last_o     ( ord_last          ),
        .ord_zero_o     ( ord_zero          ),
        .ord_valid_o    ( ord_valid         ),
        .ord_ready_i    ( ord_ready         ),
        .busy_o         ( busy_o.front_busy )
    );

    dma_read_engine i_dma_read_engine (
        .clk_i, .arst_n_i, .rd_port_o, .rd_port_i,
        .job_i        ( rd_job         ),
        .job_valid_i  ( rd_job_valid   ),
        .job_ready_o  ( rd_job_ready   ),
        .data_o       ( rd_data        ),
        .data_valid_o ( rd_data_valid  ),
        .data_ready_i ( rd_data_ready  ),
        .free_slots_i ( free_slots     ),
        .done_o       ( rd_done        ),
        .done_err_o   ( rd_err         ),
        .busy_o       ( busy_o.rd_busy )
    );

    dma_data_fifo i_dma_data_fifo (
        .clk_i, .arst_n_i,
        .data_i       ( rd_data         ),
        .valid_i      ( rd_data_valid   ),
        .ready_o      ( rd_data_ready   ),
        .data_o       ( wr_data         ),
        .valid_o      ( wr_data_valid   ),
        .ready_i      ( wr_data_ready   ),
        .free_slots_o ( free_slots      ),
        .busy_o       ( busy_o.buf_busy )
    );

    dma_write_engine i_dma_write_engine (
        .clk_i, .arst_n_i, .wr_port_o, .wr_port_i,
        .job_i        ( wr_job         ),
        .job_valid_i  ( wr_job_valid   ),
        .job_ready_o  ( wr_job_ready   ),
        .data_i       ( wr_data        ),
        .data_valid_i ( wr_data_valid  ),
        .data_ready_o ( wr_data_ready  ),
        .done_o       ( wr_done        ),
        .busy_o       ( busy_o.wr_busy )
    );

    dma_rsp_unit i_dma_rsp_unit (
        .clk_i, .arst_n_i, .dma_rsp_o, .rsp_valid_o, .rsp_ready_i,
        .ord_last_i  ( ord_last        ),
        .ord_zero_i  ( ord_zero        ),
        .ord_valid_i ( ord_valid       ),
        .ord_ready_o ( ord_ready       ),
        .rd_done_i   ( rd_done         ),
        .rd_err_i    ( rd_err          ),
        .wr_done_i   ( wr_done         ),
        .busy_o      ( busy_o.rsp_busy )
    );

endmodule

/* verification/tb_dma_backend.sv */
// Self-checking testbench for the DMA backend; random requests, memory models and a response model
`timescale 1ns/1ps
`include "dma_defs.svh"

module tb_dma_backend import dma_pkg::*; ();

    localparam int    NumReqs       = 40;
    localparam int    MaxWords      = 8;
    localparam int    WordBytes     = `DMA_DATA_WIDTH / 8;
    localparam int    SrcWords      = 64;
    localparam int    DstWords      = NumReqs * MaxWords;
    localparam int    TimeoutCycles = NumReqs * MaxWords * 40;
    localparam addr_t DstBase       = 24'h010000;

    logic         clk_i;
    logic         arst_n_i;
    dma_req_t     dma_req_i;
    logic         req_valid_i;
    logic         req_ready_o;
    dma_rsp_t     dma_rsp_o;
    logic         rsp_valid_o;
    logic         rsp_ready_i;
    rd_port_req_t rd_port_o;
    rd_port_rsp_t rd_port_i;
    wr_port_req_t wr_port_o;
    wr_port_rsp_t wr_port_i;
    dma_busy_t    busy_o;

    // Memories and request list
    data_t    src_mem [SrcWords];
    data_t    dst_mem [DstWords];
    dma_req_t req_list [NumReqs];
    dma_rsp_t exp_rsp_q [$];
    integer   seed;

    // Handshakes seen in the last sample
    logic     req_fire;
    logic     rd_fire;
    addr_t    rd_fire_addr;
    logic     rsp_stalled;
    dma_rsp_t rsp_held;
    int       sent;
    int       received;
    int       cycles;

    dma_backend i_dma_backend (.*);

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    // --------------------
    // Models
    // --------------------
    // Random table mixed with the full address, 64 words deep
    function automatic data_t src_word(addr_t addr);
        return src_mem[addr[7:2]] ^ data_t'(addr);
    endfunction

    function automatic data_t dst_fill(addr_t addr);
        return {8'ha5, addr};
    endfunction

    // Zero length, or any source word with the top address bit set, gives an error
    function automatic dma_rsp_t predict_rsp(dma_req_t req);
        dma_rsp_t rsp;
        addr_t    a;
        int       words;
        words     = int'(req.length) / WordBytes;
        rsp.last  = req.last;
        rsp.error = (words == 0);
        for (int w = 0; w < words; w++) begin
            a         = req.src_addr + addr_t'(w * WordBytes);
            rsp.error = rsp.error | a[`DMA_ADDR_WIDTH-1];
        end
        return rsp;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_rsp(input dma_rsp_t got, input dma_rsp_t exp, input int idx);
        if (got !== exp) begin
            fail_now($sformatf("Error at %0d ns: response %0d is last=%0b error=%0b, expected %0b %0b",
                               $time, idx, got.last, got.error, exp.last, exp.error));
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input addr_t addr);
        if (got !== exp) begin
            fail_now($sformatf("Error at %0d ns: word at %06h is %08h, expected %08h",
                               $time, addr, got, exp));
        end
    endtask

    task automatic check_idle(input string when);
        if (rsp_valid_o !== 1'b0 || req_ready_o !== 1'b0 || rd_port_o.req !== 1'b0 ||
            wr_port_o.req !== 1'b0 || busy_o !== '0) begin
            fail_now($sformatf("DUT outputs are not idle %s", when));
        end
    endtask

    task automatic build_requests();
        dma_req_t req;
        int       words;
        logic     top;
        for (int i = 0; i < NumReqs; i++) begin
            // About one in eight has zero length
            if (($random(seed) & 7) == 0) words = 0;
            else words = 1 + (($random(seed) & 32'h7fff_ffff) % MaxWords);
            top          = (($random(seed) & 3) == 0);
            req.src_addr = {top, 13'h0, 8'($random(seed)), 2'b00};
            // One private window of MaxWords per request
            req.dst_addr = DstBase + addr_t'(i * MaxWords * WordBytes);
            req.length   = len_t'(words * WordBytes);
            req.last     = ($random(seed) & 1) != 0;
            req_list[i]  = req;
        end
    endtask

    task automatic store_write(input addr_t addr, input data_t data);
        if (addr < DstBase || addr >= DstBase + addr_t'(DstWords * WordBytes) ||
            addr[1:0] != 2'b00) begin
            fail_now($sformatf("Write to %06h lies outside the destination windows", addr));
        end else begin
            dst_mem[(addr - DstBase) / WordBytes] = data;
        end
    endtask

    // --------------------
    // Per cycle drive and sample
    // --------------------
    task automatic drive_inputs();
        // Read data one cycle after its grant
        rd_port_i.rvalid = rd_fire;
        rd_port_i.rdata  = rd_fire ? src_word(rd_fire_addr) : '0;
        rd_port_i.rerr   = rd_fire & rd_fire_addr[`DMA_ADDR_WIDTH-1];
        rd_port_i.gnt    = ($random(seed) & 3) != 0;
        wr_port_i.gnt    = ($random(seed) & 3) != 0;
        rsp_ready_i      = ($random(seed) & 3) != 0;
        if (req_fire) begin
            req_valid_i = 1'b0;
            sent++;
        end
        // Valid holds with stable data until taken
        if (!req_valid_i && sent < NumReqs && ($random(seed) & 1) != 0) begin
            dma_req_i   = req_list[sent];
            req_valid_i = 1'b1;
        end
    endtask

    // Mid cycle, all outputs settled
    task automatic sample_outputs();
        req_fire = req_valid_i & req_ready_o;
        rd_fire  = rd_port_o.req & rd_port_i.gnt;
        if (rd_fire) rd_fire_addr = rd_port_o.addr;
        if (req_fire) exp_rsp_q.push_back(predict_rsp(req_list[sent]));
        // A stalled response keeps valid and value
        if (rsp_stalled && rsp_valid_o !== 1'b1) begin
            fail_now("Response valid dropped before the response was accepted");
        end
        if (rsp_stalled) check_rsp(dma_rsp_o, rsp_held, received);
        if (rsp_valid_o && rsp_ready_i) begin
            if (exp_rsp_q.size() == 0) begin
                fail_now("Response arrived without an outstanding request");
            end else begin
                check_rsp(dma_rsp_o, exp_rsp_q.pop_front(), received);
                received++;
            end
        end
        rsp_stalled = rsp_valid_o & ~rsp_ready_i;
        rsp_held    = dma_rsp_o;
        if (wr_port_o.req && wr_port_i.gnt) store_write(wr_port_o.addr, wr_port_o.wdata);
    endtask

    // Copied words match the source, the rest keep the fill
    task automatic check_memory();
        addr_t a;
        data_t exp;
        int    words;
        for (int i = 0; i < NumReqs; i++) begin
            words = int'(req_list[i].length) / WordBytes;
            for (int w = 0; w < MaxWords; w++) begin
                a = req_list[i].dst_addr + addr_t'(w * WordBytes);
                if (w < words) exp = src_word(req_list[i].src_addr + addr_t'(w * WordBytes));
                else exp = dst_fill(a);
                check_data(dst_mem[i * MaxWords + w], exp, a);
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        seed        = 73;
        arst_n_i    = 1'b0;
        dma_req_i   = '0;
        req_valid_i = 1'b0;
        rsp_ready_i = 1'b0;
        rd_port_i   = '0;
        wr_port_i   = '0;
        req_fire    = 1'b0;
        rd_fire     = 1'b0;
        rd_fire_addr = '0;
        rsp_stalled = 1'b0;
        rsp_held    = '0;
        sent        = 0;
        received    = 0;
        cycles      = 0;
        for (int i = 0; i < SrcWords; i++) src_mem[i] = $random(seed);
        for (int i = 0; i < DstWords; i++) dst_mem[i] = dst_fill(DstBase + addr_t'(i * WordBytes));
        build_requests();

        repeat (8) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk_i);
        check_idle("after reset");

        while (received < NumReqs) begin
            @(posedge clk_i);
            #1;
            drive_inputs();
            @(negedge clk_i);
            sample_outputs();
            cycles++;
            if (cycles >= TimeoutCycles) fail_now("Timeout while waiting for responses");
        end

        // Last response retires at this edge
        @(posedge clk_i);
        #1;
        rsp_ready_i = 1'b0;
        rd_port_i   = '0;
        wr_port_i   = '0;
        @(negedge clk_i);
        check_idle("after the last response");
        check_memory();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
src/dma_pkg.sv
src/dma_req_front.sv
src/dma_read_engine.sv
src/dma_data_fifo.sv
src/dma_write_engine.sv
src/dma_rsp_unit.sv
src/dma_backend.sv
verification/tb_dma_backend.sv

/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_dma_backend
RTL_TOP    = dma_backend
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
